// File: files.f
src/boardPkg.sv
src/regMapPkg.sv
src/keyDebounce.sv
src/regBank.sv
src/ledPager.sv
src/regViewerTop.sv
tb/regViewerTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module regViewerTb \
    --Mdir obj_dir -o regViewerSim > build.log 2>&1 &&
./obj_dir/regViewerSim > sim.log 2>&1 ||
{ echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

// File: src/boardPkg.sv
`default_nettype none

package boardPkg;

    // key timing in sysClk cycles, debounce kept short for simulation
    localparam int debounceCycles = 4;
    localparam int holdCycles = 32;    // press to first repeat
    localparam int repeatCycles = 16;  // spacing of later repeats

    localparam int keyCountMax =
        (holdCycles > repeatCycles)
            ? ((holdCycles > debounceCycles) ? holdCycles : debounceCycles)
            : ((repeatCycles > debounceCycles) ? repeatCycles : debounceCycles);

    // one width for all key counters
    localparam int keyCountWidth = $clog2(keyCountMax + 1);

endpackage

`default_nettype wire

// File: src/keyDebounce.sv
`timescale 1ns/1ps
`default_nettype none

module keyDebounce
    import boardPkg::*;
(
    input  logic sysClk,
    input  logic rstN,
    input  logic key,           // active low, asynchronous
    output logic press,
    output logic repeatPulse
);

    logic keySync0;
    logic keySync1;
    logic keyLevel;             // debounced level, 1 = released
    logic [keyCountWidth-1:0] stableCnt;
    logic [keyCountWidth-1:0] holdCnt;
    logic [keyCountWidth-1:0] holdTarget;
    logic repeating;            // first repeat already fired
    logic levelDone;
    logic fallNow;

    // synchronized level has differed for debounceCycles samples
    assign levelDone = (keySync1 != keyLevel)
                    && (stableCnt == keyCountWidth'(debounceCycles - 1));
    assign fallNow = levelDone && !keySync1;

    assign holdTarget = repeating ? keyCountWidth'(repeatCycles - 1)
                                  : keyCountWidth'(holdCycles - 1);

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            keySync0 <= 1'b1;
            keySync1 <= 1'b1;
        end else begin
            keySync0 <= key;
            keySync1 <= keySync0;
        end
    end

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            keyLevel <= 1'b1;
            stableCnt <= '0;
            press <= 1'b0;
        end else begin
            press <= fallNow;
            if (keySync1 == keyLevel) begin
                stableCnt <= '0;   // any agreeing sample restarts the count
            end else if (levelDone) begin
                stableCnt <= '0;
                keyLevel <= keySync1;
            end else begin
                stableCnt <= stableCnt + 1'b1;
            end
        end
    end

    // hold timer runs while the debounced key stays down
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            holdCnt <= '0;
            repeating <= 1'b0;
            repeatPulse <= 1'b0;
        end else begin
            repeatPulse <= 1'b0;
            if (fallNow) begin
                holdCnt <= '0;
                repeating <= 1'b0;
            end else if (!keyLevel) begin
                if (holdCnt == holdTarget) begin
                    holdCnt <= '0;
                    repeating <= 1'b1;
                    repeatPulse <= 1'b1;
                end else begin
                    holdCnt <= holdCnt + 1'b1;
                end
            end else begin
                holdCnt <= '0;     // released
                repeating <= 1'b0;
            end
        end
    end

    // the synchronized key was already down debounceCycles samples before a press
    pressAfterDebounce: assert property (
        @(posedge sysClk) disable iff (!rstN) press |-> $past(!keySync1, debounceCycles)
    ) else $error("press without a full debounce count");

endmodule

`default_nettype wire

// File: src/ledPager.sv
`timescale 1ns/1ps
`default_nettype none

module ledPager
    import regMapPkg::*;
(
    input  logic                 sysClk,
    input  logic                 rstN,
    input  logic                 upPress,
    input  logic                 upRepeat,
    input  logic                 downPress,
    input  logic                 downRepeat,
    input  logic [ledWidth-1:0]  pageData,
    output logic [pageWidth-1:0] page,      // to the bank, the page shown next cycle
    output logic [pageWidth-1:0] pageLed,
    output logic [ledWidth-1:0]  led
);

    logic upStep;
    logic downStep;
    logic [pageWidth-1:0] pageCnt;
    logic [pageWidth-1:0] pageNext;

    assign upStep = upPress | upRepeat;
    assign downStep = downPress | downRepeat;

    // opposite steps in one cycle cancel
    always_comb begin
        pageNext = pageCnt;
        if (upStep && !downStep) begin
            pageNext = (pageCnt == pageWidth'(lastPage)) ? '0 : pageCnt + 1'b1;
        end else if (downStep && !upStep) begin
            pageNext = (pageCnt == '0) ? pageWidth'(lastPage) : pageCnt - 1'b1;
        end
    end

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            pageCnt <= '0;
        end else begin
            pageCnt <= pageNext;
        end
    end

    // bank reads the next page so led and pageLed switch on the same edge
    assign page = pageNext;
    assign pageLed = pageCnt;

    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < regsPerPage; k++) begin
                led[k*$bits(regByte) +: $bits(regByte)] <= regResetValue(regAddrWidth'(k));
            end
        end else begin
            led <= pageData;   // every cycle, writes show up without a step
        end
    end

endmodule

`default_nettype wire

// File: src/regBank.sv
`timescale 1ns/1ps
`default_nettype none

module regBank
    import regMapPkg::*;
(
    input  logic                    sysClk,
    input  logic                    rstN,
    input  logic                    wrValid,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  regByte                  wrData,
    input  logic [pageWidth-1:0]    page,
    output logic [ledWidth-1:0]     pageData
);

    regByte regs [regCount];

    // one byte per cycle, no stall
    always_ff @(posedge sysClk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= regResetValue(regAddrWidth'(i));
            end
        end else if (wrValid) begin
            regs[wrAddr] <= wrData;
        end
    end

    // register 4p+k lands in byte lane k
    for (genvar k = 0; k < regsPerPage; k++) begin : gRead
        logic [regAddrWidth-1:0] rdAddr;

        assign rdAddr = regAddrWidth'(page * regsPerPage + k);
        assign pageData[k*$bits(regByte) +: $bits(regByte)] = regs[rdAddr];
    end

    wrDataKnown: assert property (
        @(posedge sysClk) disable iff (!rstN) wrValid |-> !$isunknown(wrData)
    ) else $error("write data unknown on a valid write");

endmodule

`default_nettype wire

// File: src/regMapPkg.sv
`default_nettype none

package regMapPkg;

    localparam int regCount = 64;
    localparam int regAddrWidth = $clog2(regCount);
    localparam int regsPerPage = 4;
    localparam int pageCount = regCount / regsPerPage;
    localparam int pageWidth = $clog2(pageCount);
    localparam int lastPage = pageCount - 1;   // pointer wraps here

    typedef logic [7:0] regByte;

    localparam int ledWidth = regsPerPage * $bits(regByte);

    // power-up contents of the bank
    // high nibble is the page, low nibble mixes the in-page slot with index bits 2 and 4
    function automatic regByte regResetValue(input logic [regAddrWidth-1:0] idx);
        logic [3:0] lowNib;
        lowNib = {1'b0, idx[1:0], 1'b0}
               + {3'b000, idx[2]}
               + {idx[4], 3'b000};
        return {idx[5:2], lowNib};
    endfunction

endpackage

`default_nettype wire

// File: src/regViewerTop.sv
`timescale 1ns/1ps
`default_nettype none

module regViewerTop
    import regMapPkg::*;
(
    input  logic                    sysClk,
    input  logic                    rstN,
    input  logic                    keyUp,      // active low
    input  logic                    keyDown,    // active low
    input  logic                    regWrValid,
    input  logic [regAddrWidth-1:0] regWrAddr,
    input  regByte                  regWrData,
    output logic [pageWidth-1:0]    pageLed,
    output logic [ledWidth-1:0]     led
);

    logic upPress;
    logic upRepeat;
    logic downPress;
    logic downRepeat;
    logic [pageWidth-1:0] page;
    logic [ledWidth-1:0] pageData;

    keyDebounce keyUpDebounce (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .key         (keyUp),
        .press       (upPress),
        .repeatPulse (upRepeat)
    );

    keyDebounce keyDownDebounce (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .key         (keyDown),
        .press       (downPress),
        .repeatPulse (downRepeat)
    );

    regBank regBank_i (
        .sysClk   (sysClk),
        .rstN     (rstN),
        .wrValid  (regWrValid),
        .wrAddr   (regWrAddr),
        .wrData   (regWrData),
        .page     (page),
        .pageData (pageData)
    );

    ledPager ledPager_i (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .upPress    (upPress),
        .upRepeat   (upRepeat),
        .downPress  (downPress),
        .downRepeat (downRepeat),
        .pageData   (pageData),
        .page       (page),
        .pageLed    (pageLed),
        .led        (led)
    );

endmodule

`default_nettype wire

// File: tb/regViewerTb.sv
`timescale 1ns/1ps
`default_nettype none

module regViewerTb
    import boardPkg::*;
    import regMapPkg::*;
;

    localparam int opIdle = 0;
    localparam int opUp = 1;
    localparam int opDown = 2;
    localparam int opHold = 3;   // up key held into the repeat range
    localparam int opWrite = 4;
    localparam int idleCycles = 10;
    localparam int resetCycles = 5;

    logic sysClk;
    logic rstN;
    logic keyUp;
    logic keyDown;
    logic regWrValid;
    logic [regAddrWidth-1:0] regWrAddr;
    regByte regWrData;
    logic [pageWidth-1:0] pageLed;
    logic [ledWidth-1:0] led;

    // stimulus table, one entry per index
    int opQ[$];
    int argQ[$];     // key low time in cycles, or write address
    int dataQ[$];    // write data, negative picks a random byte
    string nameQ[$];

    logic [7:0] refRegs [regCount];
    int refPage;
    int seed;
    int errorCount;
    int checkCount;
    int cycleCount = 0;
    int cycleLimit = 0;

    regViewerTop regViewerTop_i (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .keyUp      (keyUp),
        .keyDown    (keyDown),
        .regWrValid (regWrValid),
        .regWrAddr  (regWrAddr),
        .regWrData  (regWrData),
        .pageLed    (pageLed),
        .led        (led)
    );

    initial begin
        sysClk = 1'b0;
        forever #50 sysClk = ~sysClk;
    end

    always @(posedge sysClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the stimulus table did not finish", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic addEntry(input int op, input int arg, input int data, input string name);
        opQ.push_back(op);
        argQ.push_back(arg);
        dataQ.push_back(data);
        nameQ.push_back(name);
    endtask

    // byte at power-up, high nibble is the page, low nibble from slot and index bits 2 and 4
    function automatic logic [7:0] powerUpByte(input int i);
        int lowPart;
        lowPart = 2 * (i % 4) + ((i >> 2) & 1) + 8 * ((i >> 4) & 1);
        return 8'(((i / 4) << 4) | (lowPart & 15));
    endfunction

    // pulses seen for a key held len cycles: press, then repeats
    function automatic int stepsForHold(input int len);
        if (len < debounceCycles) begin
            return 0;
        end
        if (len < holdCycles) begin
            return 1;
        end
        return 2 + (len - holdCycles) / repeatCycles;
    endfunction

    function automatic logic [ledWidth-1:0] expectedLed();
        logic [ledWidth-1:0] value;
        for (int k = 0; k < regsPerPage; k++) begin
            value[k*8 +: 8] = refRegs[refPage * regsPerPage + k];
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic pressKey(input logic upSide, input int len);
        @(posedge sysClk);
        if (upSide) begin
            keyUp <= 1'b0;
        end else begin
            keyDown <= 1'b0;
        end
        repeat (len) @(posedge sysClk);
        keyUp <= 1'b1;
        keyDown <= 1'b1;
    endtask

    task automatic writeReg(input int addr, input logic [7:0] value);
        @(posedge sysClk);
        regWrValid <= 1'b1;
        regWrAddr <= regAddrWidth'(addr);
        regWrData <= value;
        @(posedge sysClk);
        regWrValid <= 1'b0;
    endtask

    task automatic applyEntry(input int e);
        int steps;
        logic [7:0] wrByte;
        steps = stepsForHold(argQ[e]);
        case (opQ[e])
            opUp, opHold: begin
                pressKey(1'b1, argQ[e]);
                refPage = (refPage + steps) % pageCount;
            end
            opDown: begin
                pressKey(1'b0, argQ[e]);
                refPage = ((refPage - steps) % pageCount + pageCount) % pageCount;
            end
            opWrite: begin
                wrByte = (dataQ[e] < 0) ? 8'($random(seed)) : 8'(dataQ[e]);
                if (wrByte == refRegs[argQ[e]]) begin
                    wrByte = ~wrByte;   // new byte always differs from the old one
                end
                writeReg(argQ[e], wrByte);
                refRegs[argQ[e]] = wrByte;
            end
            default: begin
            end
        endcase
    endtask

    task automatic buildTable();
        addEntry(opIdle, 0, 0, "after reset");
        for (int p = 1; p <= pageCount; p++) begin
            addEntry(opUp, 8, 0, $sformatf("up to page %0d", p % pageCount));
        end
        addEntry(opDown, 8, 0, "down wraps to last page");
        addEntry(opHold, holdCycles + (5 * repeatCycles) / 2, 0, "held up key repeats");
        addEntry(opWrite, 3 * regsPerPage + 1, -1, "write on current page");
        addEntry(opWrite, 5 * regsPerPage + 2, 8'h5a, "write on page 5");
        addEntry(opUp, 8, 0, "up to page 4");
        addEntry(opUp, 8, 0, "up to written page 5");
        addEntry(opUp, 2, 0, "short bounce ignored");
        addEntry(opDown, 8, 0, "down to page 4");
    endtask

    initial begin
        keyUp <= 1'b1;
        keyDown <= 1'b1;
        regWrValid <= 1'b0;
        regWrAddr <= '0;
        regWrData <= '0;
        rstN <= 1'b0;
        seed = 32'h6a75_62e1;
        errorCount = 0;
        checkCount = 0;
        refPage = 0;
        for (int i = 0; i < regCount; i++) begin
            refRegs[i] = powerUpByte(i);
        end
        buildTable();
        cycleLimit = resetCycles + 20;
        for (int e = 0; e < opQ.size(); e++) begin
            cycleLimit += idleCycles + 4 + ((opQ[e] == opWrite) ? 2 : argQ[e]);
        end

        repeat (resetCycles) @(posedge sysClk);
        rstN <= 1'b1;

        for (int e = 0; e < opQ.size(); e++) begin
            applyEntry(e);
            repeat (idleCycles) @(posedge sysClk);
            @(negedge sysClk);   // outputs settled between edges
            checkValue({nameQ[e], " pageLed"}, 32'(refPage), 32'(pageLed));
            checkValue({nameQ[e], " led"}, expectedLed(), led);
        end

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
